// File: rtl/exu_pkg.sv
`default_nettype none

package exu_pkg;

   //////////////////////////////////////////////////////////////////////
   // architectural widths
   //////////////////////////////////////////////////////////////////////

   localparam int GRLEN     = 32;
   localparam int REG_IDX_W = 5;
   localparam int LSU_OP_W  = 8;
   localparam int BRU_OP_W  = 4;
   localparam int EXCCODE_W = 6;

   // interrupts report code 0
   localparam logic [EXCCODE_W-1:0] EXCCODE_INTR = '0;

   typedef logic [REG_IDX_W-1:0] reg_idx_t;
   typedef logic [GRLEN-1:0]     gr_t;

   // one result on its way to the register file
   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      gr_t      data;
   } wb_fwd_t;

   //////////////////////////////////////////////////////////////////////
   // issue stage to execute
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                 valid;
      reg_idx_t             rs1;
      reg_idx_t             rs2;
      gr_t                  a;
      gr_t                  b;
      logic                 b_imm;
      logic                 double_read;
      gr_t                  imm_shifted;
      gr_t                  pc;
      gr_t                  bru_offset;
      logic                 lsu_valid;
      logic [LSU_OP_W-1:0]  lsu_op;
      reg_idx_t             lsu_rd;
      logic                 lsu_wen;
      logic                 bru_valid;
      logic [BRU_OP_W-1:0]  bru_op;
      logic                 mul_valid;
      logic                 mul_wen;
      logic                 alu_wen;
      reg_idx_t             rf_target;
      logic                 exception;
      logic [EXCCODE_W-1:0] exccode;
   } issue_t;

   //////////////////////////////////////////////////////////////////////
   // unit requests and responses
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                valid;
      logic [LSU_OP_W-1:0] op;
      gr_t                 base;
      gr_t                 offset;
      gr_t                 wdata;
      reg_idx_t            rd;
      logic                wen;
   } lsu_req_t;

   // completion seen at memory stage
   typedef struct packed {
      logic     finish;
      logic     wen;
      reg_idx_t rd;
      gr_t      rdata;
   } lsu_resp_t;

   typedef struct packed {
      logic                valid;
      logic [BRU_OP_W-1:0] op;
      gr_t                 a;
      gr_t                 b;
      gr_t                 pc;
      gr_t                 offset;
   } bru_req_t;

   typedef struct packed {
      logic valid;
      gr_t  a;
      gr_t  b;
   } mul_req_t;

endpackage

`default_nettype wire

// File: rtl/exu_byp_operand.sv
`default_nettype none

module exu_byp_operand
   import exu_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  reg_idx_t rs,
   input  gr_t      rf_data,
   input  logic     use_other,
   input  wb_fwd_t  fwd_m,
   input  wb_fwd_t  fwd_w,
   output gr_t      data
);

   logic hit_m;
   logic hit_w;
   logic sel_rf;
   logic sel_m;
   logic sel_w;

   // r0 is hardwired and never forwards
   assign hit_m = fwd_m.wen && (fwd_m.rd == rs) && (rs != '0) && !use_other;
   assign hit_w = fwd_w.wen && (fwd_w.rd == rs) && (rs != '0) && !use_other;

   // newer result in memory stage wins
   assign sel_m  = hit_m;
   assign sel_w  = hit_w & ~hit_m;
   assign sel_rf = ~hit_m & ~hit_w;

   // and-or mux on one-hot selects
   assign data = ({GRLEN{sel_rf}} & rf_data)
               | ({GRLEN{sel_m}}  & fwd_m.data)
               | ({GRLEN{sel_w}}  & fwd_w.data);

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   a_sel_onehot: assert property (
      @(posedge clk) disable iff (rst)
      $onehot({sel_rf, sel_m, sel_w})
   ) else $error("bypass select not one-hot for rs %0d", rs);

endmodule

`default_nettype wire

// File: rtl/exu_dispatch.sv
`default_nettype none

module exu_dispatch
   import exu_pkg::*;
(
   input  issue_t   iss,
   input  gr_t      op_a,
   input  gr_t      op_b,
   input  logic     kill,
   input  logic     bru_taken_raw,
   output lsu_req_t lsu_req,
   output bru_req_t bru_req,
   output mul_req_t mul_req,
   output logic     br_taken,
   output logic     alu_wen_e,
   output logic     mul_wen_e
);

   logic lsu_valid;
   logic bru_valid;
   logic mul_valid;
   gr_t  lsu_offset;

   // a killed instruction starts no unit
   assign lsu_valid = iss.lsu_valid & ~kill;
   assign bru_valid = iss.bru_valid & ~kill;
   assign mul_valid = iss.mul_valid & ~kill;

   //////////////////////////////////////////////////////////////////////
   // load/store
   //////////////////////////////////////////////////////////////////////

   // register+register addressing uses rs2 as offset
   assign lsu_offset = iss.double_read ? op_b : iss.imm_shifted;

   assign lsu_req = '{
      valid:  lsu_valid,
      op:     iss.lsu_op,
      base:   op_a,
      offset: lsu_offset,
      wdata:  op_b,
      rd:     iss.lsu_rd,
      wen:    iss.lsu_wen
   };

   //////////////////////////////////////////////////////////////////////
   // branch
   //////////////////////////////////////////////////////////////////////

   assign bru_req = '{
      valid:  bru_valid,
      op:     iss.bru_op,
      a:      op_a,
      b:      op_b,
      pc:     iss.pc,
      offset: iss.bru_offset
   };

   // unit answers in the same cycle
   assign br_taken = bru_valid & bru_taken_raw;

   //////////////////////////////////////////////////////////////////////
   // multiply
   //////////////////////////////////////////////////////////////////////

   assign mul_req = '{
      valid: mul_valid,
      a:     op_a,
      b:     op_b
   };

   // fixed-path write claims toward memory stage
   assign alu_wen_e = iss.alu_wen & ~kill;
   assign mul_wen_e = iss.mul_wen & ~kill;

endmodule

`default_nettype wire

// File: rtl/exu_wb_pipe.sv
`default_nettype none

module exu_wb_pipe
   import exu_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  gr_t       alu_res_e,
   input  logic      alu_wen_e,
   input  logic      mul_wen_e,
   input  reg_idx_t  rf_target_e,
   input  gr_t       link_pc_e,
   input  logic      bru_wen_e,
   input  gr_t       mul_res_m,
   input  lsu_resp_t lsu_resp,
   output wb_fwd_t   fwd_m,
   output wb_fwd_t   fwd_w
);

   // memory stage
   gr_t      alu_res_m;
   gr_t      link_pc_m;
   reg_idx_t rf_target_m;
   logic     alu_wen_m;
   logic     mul_wen_m;
   logic     bru_wen_m;

   logic     ld_claim;
   logic     wen_m;
   reg_idx_t rd_m;
   gr_t      data_m;

   // writeback stage
   logic     wen_w;
   reg_idx_t rd_w;
   gr_t      data_w;

   //////////////////////////////////////////////////////////////////////
   // execute to memory
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         alu_wen_m <= 1'b0;
         mul_wen_m <= 1'b0;
         bru_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen_e;
         mul_wen_m <= mul_wen_e;
         bru_wen_m <= bru_wen_e;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_m   <= alu_res_e;
      link_pc_m   <= link_pc_e;
      rf_target_m <= rf_target_e;
   end

   //////////////////////////////////////////////////////////////////////
   // memory stage result select
   //////////////////////////////////////////////////////////////////////

   // only a load that writes claims the memory stage
   assign ld_claim = lsu_resp.finish & lsu_resp.wen;

   // link and mul share the alu destination while a load keeps its own
   assign rd_m  = ld_claim ? lsu_resp.rd : rf_target_m;
   assign wen_m = alu_wen_m | ld_claim | bru_wen_m | mul_wen_m;

   // load > link > mul > alu
   always_comb begin
      if (ld_claim) begin
         data_m = lsu_resp.rdata;
      end else if (bru_wen_m) begin
         data_m = link_pc_m;
      end else if (mul_wen_m) begin
         data_m = mul_res_m;
      end else begin
         data_m = alu_res_m;
      end
   end

   assign fwd_m = '{wen: wen_m, rd: rd_m, data: data_m};

   //////////////////////////////////////////////////////////////////////
   // memory to writeback
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      rd_w   <= rd_m;
      data_w <= data_m;
   end

   // also the register file write port
   assign fwd_w = '{wen: wen_w, rd: rd_w, data: data_w};

   // one instruction per slot so link and mul never both claim
   a_link_mul_excl: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0({bru_wen_m, mul_wen_m})
   ) else $error("link and multiply both claim memory stage");

   a_wen_after_rst: assert property (
      @(posedge clk) rst |=> !fwd_w.wen
   ) else $error("register write enable high after reset");

endmodule

`default_nettype wire

// File: rtl/exu_trap_ctl.sv
`default_nettype none

module exu_trap_ctl
   import exu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 issue_valid,
   input  logic                 exception_e,
   input  logic [EXCCODE_W-1:0] exccode_e,
   input  logic                 lsu_ale,
   input  logic                 timer_intr,
   input  logic                 ext_intr,
   input  logic                 crmd_ie,
   input  logic                 lsu_valid_e,
   input  logic                 lsu_finish_m,
   output logic                 kill,
   output logic                 except,
   output logic [EXCCODE_W-1:0] exccode,
   output logic                 stall_req
);

   logic intr_in;
   logic intr_hold_q;
   logic intr;
   logic lsu_stall_q;

   //////////////////////////////////////////////////////////////////////
   // interrupt
   //////////////////////////////////////////////////////////////////////

   // ext_intr acts as hwi0
   assign intr_in = (timer_intr | ext_intr) & crmd_ie;

   // park the interrupt across bubbles, drop it once an instruction takes it
   always_ff @(posedge clk) begin
      if (rst) begin
         intr_hold_q <= 1'b0;
      end else if (intr_in | issue_valid) begin
         intr_hold_q <= intr_in & ~issue_valid;
      end
   end

   assign intr = (intr_in | intr_hold_q) & issue_valid;

   // only the interrupt kills, a fault still executes and gets replayed
   assign kill = intr;

   // interrupt wins over a same-cycle exception
   assign except  = exception_e | lsu_ale | intr;
   assign exccode = intr ? EXCCODE_INTR : exccode_e;

   //////////////////////////////////////////////////////////////////////
   // load/store stall
   //////////////////////////////////////////////////////////////////////

   // set by issue, cleared after finish
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_stall_q <= 1'b0;
      end else begin
         lsu_stall_q <= lsu_valid_e | (lsu_stall_q & ~lsu_finish_m);
      end
   end

   // issue cycle covered combinationally
   assign stall_req = lsu_stall_q | lsu_valid_e;

   a_finish_in_stall: assert property (
      @(posedge clk) disable iff (rst)
      lsu_finish_m |-> lsu_stall_q
   ) else $error("load/store finish with no request outstanding");

endmodule

`default_nettype wire

// File: rtl/exu_ecl.sv
`default_nettype none

module exu_ecl
   import exu_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  issue_t               iss,

   // unit results
   input  gr_t                  alu_res_e,
   input  logic                 bru_taken_raw,
   input  gr_t                  bru_link_pc_e,
   input  logic                 bru_wen_e,
   input  lsu_resp_t            lsu_resp,
   input  logic                 lsu_ale,
   input  gr_t                  mul_res_m,

   // interrupt sources
   input  logic                 timer_intr,
   input  logic                 ext_intr,
   input  logic                 crmd_ie,

   // bypassed operands and unit requests
   output gr_t                  alu_a,
   output gr_t                  alu_b,
   output lsu_req_t             lsu_req,
   output bru_req_t             bru_req,
   output mul_req_t             mul_req,
   output logic                 br_taken,

   // register file, issue control
   output wb_fwd_t              rf_wr,
   output logic                 stall_req,
   output logic                 except,
   output logic [EXCCODE_W-1:0] exccode
);

   wb_fwd_t fwd_m;
   logic    kill;
   logic    alu_wen_e;
   logic    mul_wen_e;

   //////////////////////////////////////////////////////////////////////
   // operand bypass
   //////////////////////////////////////////////////////////////////////

   exu_byp_operand u_byp_rs1 (
      .clk       (clk),
      .rst       (rst),
      .rs        (iss.rs1),
      .rf_data   (iss.a),
      .use_other (1'b0),
      .fwd_m     (fwd_m),
      .fwd_w     (rf_wr),
      .data      (alu_a)
   );

   // immediate or double-read b comes from elsewhere
   exu_byp_operand u_byp_rs2 (
      .clk       (clk),
      .rst       (rst),
      .rs        (iss.rs2),
      .rf_data   (iss.b),
      .use_other (iss.b_imm | iss.double_read),
      .fwd_m     (fwd_m),
      .fwd_w     (rf_wr),
      .data      (alu_b)
   );

   //////////////////////////////////////////////////////////////////////
   // dispatch, writeback, trap
   //////////////////////////////////////////////////////////////////////

   exu_dispatch u_dispatch (
      .iss           (iss),
      .op_a          (alu_a),
      .op_b          (alu_b),
      .kill          (kill),
      .bru_taken_raw (bru_taken_raw),
      .lsu_req       (lsu_req),
      .bru_req       (bru_req),
      .mul_req       (mul_req),
      .br_taken      (br_taken),
      .alu_wen_e     (alu_wen_e),
      .mul_wen_e     (mul_wen_e)
   );

   exu_wb_pipe u_wb_pipe (
      .clk         (clk),
      .rst         (rst),
      .alu_res_e   (alu_res_e),
      .alu_wen_e   (alu_wen_e),
      .mul_wen_e   (mul_wen_e),
      .rf_target_e (iss.rf_target),
      .link_pc_e   (bru_link_pc_e),
      .bru_wen_e   (bru_wen_e),
      .mul_res_m   (mul_res_m),
      .lsu_resp    (lsu_resp),
      .fwd_m       (fwd_m),
      .fwd_w       (rf_wr)
   );

   exu_trap_ctl u_trap_ctl (
      .clk          (clk),
      .rst          (rst),
      .issue_valid  (iss.valid),
      .exception_e  (iss.exception),
      .exccode_e    (iss.exccode),
      .lsu_ale      (lsu_ale),
      .timer_intr   (timer_intr),
      .ext_intr     (ext_intr),
      .crmd_ie      (crmd_ie),
      .lsu_valid_e  (lsu_req.valid),
      .lsu_finish_m (lsu_resp.finish),
      .kill         (kill),
      .except       (except),
      .exccode      (exccode),
      .stall_req    (stall_req)
   );

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst
);

   timeunit 1ns;
   timeprecision 1ps;

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // held for 4 rising edges, released on an edge
   initial begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: dv/exu_ecl_tb.sv
`default_nettype none

module exu_ecl_tb
   import exu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   logic                 clk;
   logic                 rst;

   issue_t               iss;
   gr_t                  alu_res_e;
   logic                 bru_taken_raw;
   gr_t                  bru_link_pc_e;
   logic                 bru_wen_e;
   lsu_resp_t            lsu_resp;
   logic                 lsu_ale;
   gr_t                  mul_res_m;
   logic                 timer_intr;
   logic                 ext_intr;
   logic                 crmd_ie;

   gr_t                  alu_a;
   gr_t                  alu_b;
   lsu_req_t             lsu_req;
   bru_req_t             bru_req;
   mul_req_t             mul_req;
   logic                 br_taken;
   wb_fwd_t              rf_wr;
   logic                 stall_req;
   logic                 except;
   logic [EXCCODE_W-1:0] exccode;

   // multiply result for the cycle after the current one
   gr_t                  mul_next;
   reg_idx_t             recent [2];

   // reference model
   logic                 intr_in;
   logic                 intr_held;
   logic                 exp_kill;
   logic                 exp_except;
   logic [EXCCODE_W-1:0] exp_exccode;
   logic                 ld_out;
   logic                 exp_stall;
   logic                 exp_lsu_v;
   logic                 exp_bru_v;
   logic                 exp_mul_v;
   logic                 exp_taken;
   wb_fwd_t              exp_e;
   wb_fwd_t              exp_mq;
   wb_fwd_t              exp_m;
   wb_fwd_t              exp_w;
   gr_t                  exp_a;
   gr_t                  exp_b;
   gr_t                  exp_off;
   lsu_req_t             exp_lsu;
   bru_req_t             exp_bru;
   mul_req_t             exp_mul;

   tb_clk_gen u_clk (
      .clk (clk),
      .rst (rst)
   );

   exu_ecl dut (
      .clk           (clk),
      .rst           (rst),
      .iss           (iss),
      .alu_res_e     (alu_res_e),
      .bru_taken_raw (bru_taken_raw),
      .bru_link_pc_e (bru_link_pc_e),
      .bru_wen_e     (bru_wen_e),
      .lsu_resp      (lsu_resp),
      .lsu_ale       (lsu_ale),
      .mul_res_m     (mul_res_m),
      .timer_intr    (timer_intr),
      .ext_intr      (ext_intr),
      .crmd_ie       (crmd_ie),
      .alu_a         (alu_a),
      .alu_b         (alu_b),
      .lsu_req       (lsu_req),
      .bru_req       (bru_req),
      .mul_req       (mul_req),
      .br_taken      (br_taken),
      .rf_wr         (rf_wr),
      .stall_req     (stall_req),
      .except        (except),
      .exccode       (exccode)
   );

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string sig, input logic [159:0] got,
                                  input logic [159:0] exp);
      stop_on_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", sig, got, exp));
   endtask

   // newest matching write wins while r0 and disabled ports read the register file
   function automatic gr_t fwd_pick(input reg_idx_t rs, input gr_t rf, input logic off,
                                    input wb_fwd_t m, input wb_fwd_t w);
      gr_t v;
      v = rf;
      if (!off && rs != '0) begin
         if (m.wen && m.rd == rs) begin
            v = m.data;
         end else if (w.wen && w.rd == rs) begin
            v = w.data;
         end
      end
      return v;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   assign intr_in     = (timer_intr | ext_intr) & crmd_ie;
   assign exp_kill    = iss.valid & (intr_in | intr_held);
   assign exp_except  = iss.exception | lsu_ale | exp_kill;
   assign exp_exccode = exp_kill ? EXCCODE_INTR : iss.exccode;
   assign exp_lsu_v   = iss.lsu_valid & ~exp_kill;
   assign exp_bru_v   = iss.bru_valid & ~exp_kill;
   assign exp_mul_v   = iss.mul_valid & ~exp_kill;
   assign exp_taken   = exp_bru_v & bru_taken_raw;
   assign exp_stall   = ld_out | exp_lsu_v;

   assign exp_a   = fwd_pick(iss.rs1, iss.a, 1'b0, exp_m, exp_w);
   assign exp_b   = fwd_pick(iss.rs2, iss.b, iss.b_imm | iss.double_read, exp_m, exp_w);
   assign exp_off = iss.double_read ? exp_b : iss.imm_shifted;

   // unit requests carry the bypassed operands
   assign exp_lsu = '{valid: exp_lsu_v, op: iss.lsu_op, base: exp_a, offset: exp_off,
                      wdata: exp_b, rd: iss.lsu_rd, wen: iss.lsu_wen};
   assign exp_bru = '{valid: exp_bru_v, op: iss.bru_op, a: exp_a, b: exp_b,
                      pc: iss.pc, offset: iss.bru_offset};
   assign exp_mul = '{valid: exp_mul_v, a: exp_a, b: exp_b};

   // write claimed at execute with link over mul over alu
   always_comb begin
      exp_e    = '0;
      exp_e.rd = iss.rf_target;
      if (iss.valid && !exp_kill) begin
         if (bru_wen_e) begin
            exp_e.wen  = 1'b1;
            exp_e.data = bru_link_pc_e;
         end else if (iss.mul_wen) begin
            exp_e.wen  = 1'b1;
            exp_e.data = mul_next;
         end else if (iss.alu_wen) begin
            exp_e.wen  = 1'b1;
            exp_e.data = alu_res_e;
         end
      end
   end

   // a finishing load takes the memory stage
   always_comb begin
      exp_m = exp_mq;
      if (lsu_resp.finish && lsu_resp.wen) begin
         exp_m = '{wen: 1'b1, rd: lsu_resp.rd, data: lsu_resp.rdata};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         exp_mq    <= '0;
         exp_w     <= '0;
         intr_held <= 1'b0;
         ld_out    <= 1'b0;
      end else begin
         exp_mq <= exp_e;
         exp_w  <= exp_m;
         if (iss.valid) begin
            intr_held <= 1'b0;
         end else if (intr_in) begin
            intr_held <= 1'b1;
         end
         if (exp_lsu_v) begin
            ld_out <= 1'b1;
         end else if (lsu_resp.finish) begin
            ld_out <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   a_reset: assert property (@(posedge clk) rst |=> (!rf_wr.wen && !stall_req && !except))
      else stop_on_error("register write, stall or exception active after reset");

   a_wr_wen: assert property (@(posedge clk) disable iff (rst) rf_wr.wen == exp_w.wen)
      else report_mismatch("rf_wr.wen", 32'($sampled(rf_wr.wen)), 32'($sampled(exp_w.wen)));
   a_wr_rd: assert property (@(posedge clk) disable iff (rst)
      exp_w.wen |-> rf_wr.rd == exp_w.rd)
      else report_mismatch("rf_wr.rd", 32'($sampled(rf_wr.rd)), 32'($sampled(exp_w.rd)));
   a_wr_data: assert property (@(posedge clk) disable iff (rst)
      exp_w.wen |-> rf_wr.data == exp_w.data)
      else report_mismatch("rf_wr.data", $sampled(rf_wr.data), $sampled(exp_w.data));

   a_alu_a: assert property (@(posedge clk) disable iff (rst) iss.valid |-> alu_a == exp_a)
      else report_mismatch("alu_a", $sampled(alu_a), $sampled(exp_a));
   a_alu_b: assert property (@(posedge clk) disable iff (rst) iss.valid |-> alu_b == exp_b)
      else report_mismatch("alu_b", $sampled(alu_b), $sampled(exp_b));

   a_lsu_req: assert property (@(posedge clk) disable iff (rst)
      iss.valid |-> lsu_req == exp_lsu)
      else report_mismatch("lsu_req", $sampled(lsu_req), $sampled(exp_lsu));
   a_bru_req: assert property (@(posedge clk) disable iff (rst)
      iss.valid |-> bru_req == exp_bru)
      else report_mismatch("bru_req", $sampled(bru_req), $sampled(exp_bru));
   a_mul_req: assert property (@(posedge clk) disable iff (rst)
      iss.valid |-> mul_req == exp_mul)
      else report_mismatch("mul_req", $sampled(mul_req), $sampled(exp_mul));

   a_stall: assert property (@(posedge clk) disable iff (rst) stall_req == exp_stall)
      else report_mismatch("stall_req", 32'($sampled(stall_req)), 32'($sampled(exp_stall)));

   a_lsu_v: assert property (@(posedge clk) disable iff (rst) lsu_req.valid == exp_lsu_v)
      else report_mismatch("lsu_req.valid", 32'($sampled(lsu_req.valid)),
                           32'($sampled(exp_lsu_v)));
   a_bru_v: assert property (@(posedge clk) disable iff (rst) bru_req.valid == exp_bru_v)
      else report_mismatch("bru_req.valid", 32'($sampled(bru_req.valid)),
                           32'($sampled(exp_bru_v)));
   a_mul_v: assert property (@(posedge clk) disable iff (rst) mul_req.valid == exp_mul_v)
      else report_mismatch("mul_req.valid", 32'($sampled(mul_req.valid)),
                           32'($sampled(exp_mul_v)));
   a_taken: assert property (@(posedge clk) disable iff (rst) br_taken == exp_taken)
      else report_mismatch("br_taken", 32'($sampled(br_taken)), 32'($sampled(exp_taken)));

   a_except: assert property (@(posedge clk) disable iff (rst) except == exp_except)
      else report_mismatch("except", 32'($sampled(except)), 32'($sampled(exp_except)));
   a_exccode: assert property (@(posedge clk) disable iff (rst)
      exp_except |-> exccode == exp_exccode)
      else report_mismatch("exccode", 32'($sampled(exccode)), 32'($sampled(exp_exccode)));

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic note_target(input reg_idx_t rd);
      recent[1] = recent[0];
      recent[0] = rd;
   endtask

   // mostly recent targets so forwarding gets hit
   function automatic reg_idx_t pick_src();
      reg_idx_t r;
      case ($urandom_range(3))
         0: r = recent[0];
         1: r = recent[1];
         default: r = reg_idx_t'($urandom_range(31));
      endcase
      return r;
   endfunction

   function automatic issue_t rand_issue();
      issue_t t;
      t             = '0;
      t.valid       = 1'b1;
      t.rs1         = pick_src();
      t.rs2         = pick_src();
      t.a           = $urandom();
      t.b           = $urandom();
      t.b_imm       = ($urandom_range(3) == 0);
      t.double_read = ($urandom_range(3) == 0);
      t.imm_shifted = $urandom();
      t.pc          = $urandom();
      t.bru_offset  = $urandom();
      t.lsu_op      = LSU_OP_W'($urandom_range(255));
      t.bru_op      = BRU_OP_W'($urandom_range(15));
      t.rf_target   = pick_src();
      t.exccode     = EXCCODE_W'($urandom_range(63, 1));
      return t;
   endfunction

   // one execute cycle
   task automatic drive(input issue_t t, input logic link_wen = 1'b0,
                        input lsu_resp_t resp = '0, input logic tmr = 1'b0,
                        input logic ext = 1'b0, input logic ie = 1'b1);
      @(posedge clk);
      iss           <= t;
      alu_res_e     <= $urandom();
      bru_taken_raw <= 1'($urandom_range(1));
      bru_link_pc_e <= $urandom();
      bru_wen_e     <= link_wen;
      lsu_resp      <= resp;
      lsu_ale       <= t.lsu_valid && ($urandom_range(3) == 0);
      mul_res_m     <= mul_next;
      mul_next      <= $urandom();
      timer_intr    <= tmr;
      ext_intr      <= ext;
      crmd_ie       <= ie;
      if (t.valid && (t.alu_wen || t.mul_wen || link_wen)) begin
         note_target(t.rf_target);
      end
   endtask

   task automatic wait_stall_clear();
      int n;
      n = 0;
      @(negedge clk);
      while (stall_req) begin
         n++;
         if (n > 16) begin
            stop_on_error("stall_req did not fall after load/store finish");
         end
         @(negedge clk);
      end
   endtask

   // issue then finish after a random latency
   task automatic run_lsu(input issue_t t);
      lsu_resp_t r;
      int        d;
      t.lsu_valid = 1'b1;
      t.lsu_wen   = 1'($urandom_range(1));
      t.lsu_rd    = pick_src();
      d           = int'($urandom_range(4, 1));
      drive(t);
      repeat (d - 1) drive('0);
      r.finish = 1'b1;
      r.wen    = t.lsu_wen;
      r.rd     = t.lsu_rd;
      r.rdata  = $urandom();
      drive('0, 1'b0, r);
      drive('0);
      wait_stall_clear();
      if (t.lsu_wen) begin
         note_target(t.lsu_rd);
      end
   endtask

   initial begin
      issue_t t;
      int     n;
      iss           = '0;
      alu_res_e     = '0;
      bru_taken_raw = 1'b0;
      bru_link_pc_e = '0;
      bru_wen_e     = 1'b0;
      lsu_resp      = '0;
      lsu_ale       = 1'b0;
      mul_res_m     = '0;
      timer_intr    = 1'b0;
      ext_intr      = 1'b0;
      crmd_ie       = 1'b1;
      mul_next      = '0;
      recent[0]     = '0;
      recent[1]     = '0;
      void'($urandom(57526));

      n = 0;
      @(negedge clk);
      while (rst) begin
         n++;
         if (n > 16) begin
            stop_on_error("reset was never released");
         end
         @(negedge clk);
      end
      repeat (2) drive('0);

      // mixed traffic without interrupts
      for (int i = 0; i < 400; i++) begin
         t = rand_issue();
         case ($urandom_range(7))
            0: drive('0);
            1, 2: begin
               t.alu_wen = 1'b1;
               drive(t);
            end
            3: begin
               t.bru_valid = 1'b1;
               t.alu_wen   = 1'($urandom_range(1));
               drive(t, 1'b1);
            end
            4: begin
               t.mul_valid = 1'b1;
               t.mul_wen   = 1'b1;
               drive(t);
            end
            5: begin
               t.bru_valid = 1'b1;
               drive(t);
            end
            6: run_lsu(t);
            default: begin
               t.exception = 1'b1;
               t.alu_wen   = 1'($urandom_range(1));
               t.bru_valid = 1'($urandom_range(1));
               t.mul_valid = 1'($urandom_range(1));
               drive(t);
            end
         endcase
      end

      //////////////////////////////////////////////////////////////////////
      // interrupts
      //////////////////////////////////////////////////////////////////////

      // raised in a bubble and taken by the next issue
      for (int k = 0; k < 8; k++) begin
         drive('0, 1'b0, '0, k[0], ~k[0]);
         repeat (k % 3) drive('0);
         t           = rand_issue();
         t.lsu_valid = 1'b1;
         t.bru_valid = 1'b1;
         t.mul_valid = 1'b1;
         t.mul_wen   = 1'b1;
         t.exception = k[1];
         drive(t);
         drive('0);
      end

      // meets a valid instruction directly
      t           = rand_issue();
      t.bru_valid = 1'b1;
      t.alu_wen   = 1'b1;
      drive(t, 1'b0, '0, 1'b1, 1'b0);

      // masked interrupt is not held
      drive('0, 1'b0, '0, 1'b1, 1'b1, 1'b0);
      t         = rand_issue();
      t.alu_wen = 1'b1;
      drive(t);

      repeat (4) drive('0);
      @(negedge clk);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
rtl/exu_pkg.sv
rtl/exu_byp_operand.sv
rtl/exu_dispatch.sv
rtl/exu_wb_pipe.sv
rtl/exu_trap_ctl.sv
rtl/exu_ecl.sv
dv/tb_clk_gen.sv
dv/exu_ecl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute-stage testbench with Verilator
# exit status is nonzero when the build fails or the testbench stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
   -f project.f --top-module exu_ecl_tb \
   -Mdir obj_dir -o exu_ecl_sim \
   && ./obj_dir/exu_ecl_sim \
   || exit 1
